// ==== design/cpu_pkg.sv ====
package cpu_pkg;

    localparam logic [31:0] reset_pc = 32'h1c00_0000;

    localparam int reg_addr_w = 5;
    localparam int alu_op_w   = 12;

    // one-hot alu operation indices
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

    // three field layouts over the same instruction word
    typedef union packed {
        struct packed {
            logic [16:0] opcode;
            logic [4:0]  rk;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } r_fmt;
        struct packed {
            logic [9:0]  opcode;
            logic [11:0] si12;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } i12_fmt;
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] offs16;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } i16_fmt;
    } inst_word_t;

endpackage

// ==== design/fetch_stage.sv ====
`timescale 1ns/100ps

module fetch_stage (
    input  logic        clk,
    input  logic        reset,
    input  logic        start_fetch,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    output logic        inst_sram_en,
    output logic [31:0] inst_sram_addr,
    output logic        fetch_done,
    output logic [31:0] fetch_pc
);
    import cpu_pkg::*;

    logic        boot;
    logic [31:0] pc;

    // boot is high for the single cycle after reset and launches the first fetch
    always_ff @(posedge clk) begin
        if (reset) begin
            boot         <= 1'b1;
            inst_sram_en <= 1'b0;
            fetch_done   <= 1'b0;
            pc           <= reset_pc;
        end else begin
            boot         <= 1'b0;
            inst_sram_en <= boot | start_fetch;
            fetch_done   <= inst_sram_en;
            if (start_fetch) begin
                pc <= redirect ? redirect_pc : pc + 32'd4;
            end
        end
    end

    // pc holds still until the instruction retires
    assign inst_sram_addr = pc;
    assign fetch_pc       = pc;

endmodule

// ==== design/decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          fetch_done,
    input  logic [31:0]                   fetch_pc,
    input  logic [31:0]                   inst_sram_rdata,
    output logic [cpu_pkg::reg_addr_w-1:0] rf_raddr1,
    output logic [cpu_pkg::reg_addr_w-1:0] rf_raddr2,
    output logic                          issue,
    output logic [31:0]                   dec_pc,
    output logic [cpu_pkg::alu_op_w-1:0]   alu_op,
    output logic                          src1_is_pc,
    output logic                          src2_is_imm,
    output logic [31:0]                   imm,
    output logic [31:0]                   br_offs,
    output logic                          is_beq,
    output logic                          is_bne,
    output logic                          is_jump,
    output logic                          is_jirl,
    output logic                          mem_we,
    output logic                          mem_re,
    output logic                          gr_we,
    output logic [cpu_pkg::reg_addr_w-1:0] dest
);
    import cpu_pkg::*;

    inst_word_t  inst_q;
    logic [4:0]  rd, rj, rk;
    logic [11:0] si12;
    logic [19:0] si20;
    logic [15:0] offs16;
    logic [25:0] offs26;
    logic inst_add_w, inst_sub_w, inst_slt, inst_sltu, inst_nor, inst_and, inst_or, inst_xor;
    logic inst_slli_w, inst_srli_w, inst_srai_w, inst_addi_w, inst_lu12i_w;
    logic inst_ld_w, inst_st_w, inst_jirl, inst_b, inst_bl, inst_beq, inst_bne;
    logic need_ui5, need_si20, need_si26, src2_is_4;

    always_ff @(posedge clk) begin
        if (reset) begin
            issue <= 1'b0;
        end else begin
            issue <= fetch_done;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_done) begin
            inst_q <= inst_sram_rdata;
            dec_pc <= fetch_pc;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // field extraction
    assign rd     = inst_q.r_fmt.rd;
    assign rj     = inst_q.r_fmt.rj;
    assign rk     = inst_q.r_fmt.rk;
    assign si12   = inst_q.i12_fmt.si12;
    assign offs16 = inst_q.i16_fmt.offs16;
    assign si20   = {inst_q.i16_fmt.offs16[14:0], inst_q.i16_fmt.rj};
    assign offs26 = {inst_q.i16_fmt.rj, inst_q.i16_fmt.rd, inst_q.i16_fmt.offs16};

    // 17-bit opcodes of register and shift forms
    assign inst_add_w  = inst_q.r_fmt.opcode == 17'h00020;
    assign inst_sub_w  = inst_q.r_fmt.opcode == 17'h00022;
    assign inst_slt    = inst_q.r_fmt.opcode == 17'h00024;
    assign inst_sltu   = inst_q.r_fmt.opcode == 17'h00025;
    assign inst_nor    = inst_q.r_fmt.opcode == 17'h00028;
    assign inst_and    = inst_q.r_fmt.opcode == 17'h00029;
    assign inst_or     = inst_q.r_fmt.opcode == 17'h0002a;
    assign inst_xor    = inst_q.r_fmt.opcode == 17'h0002b;
    assign inst_slli_w = inst_q.r_fmt.opcode == 17'h00081;
    assign inst_srli_w = inst_q.r_fmt.opcode == 17'h00089;
    assign inst_srai_w = inst_q.r_fmt.opcode == 17'h00091;

    assign inst_addi_w = inst_q.i12_fmt.opcode == 10'h00a;
    assign inst_ld_w   = inst_q.i12_fmt.opcode == 10'h0a2;
    assign inst_st_w   = inst_q.i12_fmt.opcode == 10'h0a6;

    assign inst_jirl    = inst_q.i16_fmt.opcode == 6'h13;
    assign inst_b       = inst_q.i16_fmt.opcode == 6'h14;
    assign inst_bl      = inst_q.i16_fmt.opcode == 6'h15;
    assign inst_beq     = inst_q.i16_fmt.opcode == 6'h16;
    assign inst_bne     = inst_q.i16_fmt.opcode == 6'h17;
    assign inst_lu12i_w = inst_q.i16_fmt.opcode == 6'h05 && !offs16[15];

    ////////////////////////////////////////////////////////////////////////////
    // control generation
    assign alu_op[alu_add]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                              | inst_jirl | inst_bl;
    assign alu_op[alu_sub]  = inst_sub_w;
    assign alu_op[alu_slt]  = inst_slt;
    assign alu_op[alu_sltu] = inst_sltu;
    assign alu_op[alu_and]  = inst_and;
    assign alu_op[alu_nor]  = inst_nor;
    assign alu_op[alu_or]   = inst_or;
    assign alu_op[alu_xor]  = inst_xor;
    assign alu_op[alu_sll]  = inst_slli_w;
    assign alu_op[alu_srl]  = inst_srli_w;
    assign alu_op[alu_sra]  = inst_srai_w;
    assign alu_op[alu_lui]  = inst_lu12i_w;

    assign need_ui5  = inst_slli_w | inst_srli_w | inst_srai_w;
    assign need_si20 = inst_lu12i_w;
    assign need_si26 = inst_b | inst_bl;
    assign src2_is_4 = inst_jirl | inst_bl;

    // links add 4 to the pc in the alu
    assign imm = src2_is_4 ? 32'd4 :
                 need_si20 ? {si20, 12'b0} :
                 need_ui5  ? {27'b0, rk} :
                 {{20{si12[11]}}, si12};

    assign br_offs = need_si26 ? {{4{offs26[25]}}, offs26, 2'b0} :
                                 {{14{offs16[15]}}, offs16, 2'b0};

    assign src1_is_pc  = inst_jirl | inst_bl;
    assign src2_is_imm = need_ui5 | inst_addi_w | inst_ld_w | inst_st_w | inst_lu12i_w
                         | src2_is_4;

    assign is_beq  = inst_beq;
    assign is_bne  = inst_bne;
    assign is_jump = inst_b | inst_bl;
    assign is_jirl = inst_jirl;
    assign mem_we  = inst_st_w;
    assign mem_re  = inst_ld_w;
    assign gr_we   = ~inst_st_w & ~inst_beq & ~inst_bne & ~inst_b;
    assign dest    = inst_bl ? 5'd1 : rd;

    // compares and stores read rd on the second port
    assign rf_raddr1 = rj;
    assign rf_raddr2 = (inst_beq | inst_bne | inst_st_w) ? rd : rk;

endmodule

// ==== design/regfile.sv ====
`timescale 1ns/100ps

module regfile (
    input  logic                          clk,
    input  logic [cpu_pkg::reg_addr_w-1:0] raddr1,
    input  logic [cpu_pkg::reg_addr_w-1:0] raddr2,
    output logic [31:0]                   rdata1,
    output logic [31:0]                   rdata2,
    input  logic                          we,
    input  logic [cpu_pkg::reg_addr_w-1:0] waddr,
    input  logic [31:0]                   wdata
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is never written, so its read is forced
    assign rdata1 = (raddr1 == '0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? 32'd0 : regs[raddr2];

endmodule

// ==== design/execute_stage.sv ====
`timescale 1ns/100ps

module execute_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          issue,
    input  logic [31:0]                   dec_pc,
    input  logic [cpu_pkg::alu_op_w-1:0]   alu_op,
    input  logic                          src1_is_pc,
    input  logic                          src2_is_imm,
    input  logic [31:0]                   imm,
    input  logic [31:0]                   br_offs,
    input  logic                          is_beq,
    input  logic                          is_bne,
    input  logic                          is_jump,
    input  logic                          is_jirl,
    input  logic                          mem_we,
    input  logic                          mem_re,
    input  logic                          gr_we,
    input  logic [cpu_pkg::reg_addr_w-1:0] dest,
    input  logic [31:0]                   rj_value,
    input  logic [31:0]                   rkd_value,
    output logic                          redirect,
    output logic [31:0]                   redirect_pc,
    output logic                          retire_now,
    output logic                          to_wb,
    output logic                          wb_is_load,
    output logic [31:0]                   wb_pc,
    output logic [cpu_pkg::reg_addr_w-1:0] wb_dest,
    output logic [31:0]                   wb_alu_result,
    output logic                          data_sram_en,
    output logic                          data_sram_we,
    output logic [31:0]                   data_sram_addr,
    output logic [31:0]                   data_sram_wdata
);
    import cpu_pkg::*;

    logic [31:0] alu_src1, alu_src2, alu_result, sum, diff;
    logic        slt_res, sltu_res, taken;
    logic        link_q, ld_wait;

    ////////////////////////////////////////////////////////////////////////////
    // alu
    assign alu_src1 = src1_is_pc  ? dec_pc : rj_value;
    assign alu_src2 = src2_is_imm ? imm    : rkd_value;
    assign sum      = alu_src1 + alu_src2;
    assign diff     = alu_src1 - alu_src2;
    assign slt_res  = $signed(alu_src1) < $signed(alu_src2);
    assign sltu_res = alu_src1 < alu_src2;

    assign alu_result = ({32{alu_op[alu_add]}}  & sum)
                      | ({32{alu_op[alu_sub]}}  & diff)
                      | ({32{alu_op[alu_slt]}}  & {31'b0, slt_res})
                      | ({32{alu_op[alu_sltu]}} & {31'b0, sltu_res})
                      | ({32{alu_op[alu_and]}}  & (alu_src1 & alu_src2))
                      | ({32{alu_op[alu_nor]}}  & ~(alu_src1 | alu_src2))
                      | ({32{alu_op[alu_or]}}   & (alu_src1 | alu_src2))
                      | ({32{alu_op[alu_xor]}}  & (alu_src1 ^ alu_src2))
                      | ({32{alu_op[alu_sll]}}  & (alu_src1 << alu_src2[4:0]))
                      | ({32{alu_op[alu_srl]}}  & (alu_src1 >> alu_src2[4:0]))
                      | ({32{alu_op[alu_sra]}}  & 32'($signed(alu_src1) >>> alu_src2[4:0]))
                      | ({32{alu_op[alu_lui]}}  & alu_src2);

    ////////////////////////////////////////////////////////////////////////////
    // branch resolution
    assign taken = is_jump | is_jirl
                 | (is_beq && rj_value == rkd_value)
                 | (is_bne && rj_value != rkd_value);

    // decode outputs hold until the next fetch, so the target is still valid for link_q
    assign redirect_pc = is_jirl ? rj_value + br_offs : dec_pc + br_offs;
    assign redirect    = (issue & taken & ~gr_we) | link_q;
    assign retire_now  = issue & ~gr_we;

    // links redirect together with their writeback; loads wait one cycle for rdata
    always_ff @(posedge clk) begin
        if (reset) begin
            link_q  <= 1'b0;
            ld_wait <= 1'b0;
        end else begin
            link_q  <= issue & gr_we & (is_jump | is_jirl);
            ld_wait <= issue & mem_re;
        end
    end

    assign to_wb         = (issue & gr_we & ~mem_re) | ld_wait;
    assign wb_is_load    = ld_wait;
    assign wb_pc         = dec_pc;
    assign wb_dest       = dest;
    assign wb_alu_result = alu_result;

    assign data_sram_en    = issue & (mem_re | mem_we);
    assign data_sram_we    = issue & mem_we;
    assign data_sram_addr  = alu_result;
    assign data_sram_wdata = rkd_value;

endmodule

// ==== design/writeback_stage.sv ====
`timescale 1ns/100ps

module writeback_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          to_wb,
    input  logic                          wb_is_load,
    input  logic [31:0]                   wb_pc,
    input  logic [cpu_pkg::reg_addr_w-1:0] wb_dest,
    input  logic [31:0]                   wb_alu_result,
    input  logic [31:0]                   data_sram_rdata,
    output logic                          rf_we,
    output logic [cpu_pkg::reg_addr_w-1:0] rf_waddr,
    output logic [31:0]                   rf_wdata,
    output logic                          wb_done,
    output logic [31:0]                   debug_wb_pc
);

    always_ff @(posedge clk) begin
        if (reset) begin
            rf_we <= 1'b0;
        end else begin
            rf_we <= to_wb;
        end
    end

    // load data is valid in the same cycle as to_wb
    always_ff @(posedge clk) begin
        if (to_wb) begin
            rf_waddr    <= wb_dest;
            rf_wdata    <= wb_is_load ? data_sram_rdata : wb_alu_result;
            debug_wb_pc <= wb_pc;
        end
    end

    assign wb_done = rf_we;

endmodule

// ==== design/cpu_top.sv ====
`timescale 1ns/100ps

module cpu_top (
    input  logic        clk,
    input  logic        reset,
    output logic        inst_sram_en,
    output logic [31:0] inst_sram_addr,
    input  logic [31:0] inst_sram_rdata,
    output logic        data_sram_en,
    output logic        data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,
    output logic [31:0] debug_wb_pc,
    output logic        debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);
    import cpu_pkg::*;

    logic                  start_fetch, redirect, retire_now, fetch_done, issue;
    logic [31:0]           redirect_pc, fetch_pc, dec_pc, imm, br_offs;
    logic [reg_addr_w-1:0] rf_raddr1, rf_raddr2, dest, wb_dest;
    logic [alu_op_w-1:0]   alu_op;
    logic                  src1_is_pc, src2_is_imm, is_beq, is_bne, is_jump, is_jirl;
    logic                  mem_we, mem_re, gr_we, to_wb, wb_is_load, wb_done;
    logic [31:0]           rj_value, rkd_value, wb_pc, wb_alu_result;

    ////////////////////////////////////////////////////////////////////////////
    // one instruction in flight, next fetch after it retires
    assign start_fetch = retire_now | wb_done;

    fetch_stage u_fetch (
        .clk, .reset, .start_fetch, .redirect, .redirect_pc,
        .inst_sram_en, .inst_sram_addr, .fetch_done, .fetch_pc
    );

    decode_stage u_decode (
        .clk, .reset, .fetch_done, .fetch_pc, .inst_sram_rdata,
        .rf_raddr1, .rf_raddr2, .issue, .dec_pc, .alu_op, .src1_is_pc, .src2_is_imm,
        .imm, .br_offs, .is_beq, .is_bne, .is_jump, .is_jirl, .mem_we, .mem_re,
        .gr_we, .dest
    );

    regfile u_regfile (
        .clk, .raddr1(rf_raddr1), .raddr2(rf_raddr2), .rdata1(rj_value),
        .rdata2(rkd_value), .we(debug_wb_rf_we), .waddr(debug_wb_rf_wnum),
        .wdata(debug_wb_rf_wdata)
    );

    execute_stage u_execute (
        .clk, .reset, .issue, .dec_pc, .alu_op, .src1_is_pc, .src2_is_imm, .imm,
        .br_offs, .is_beq, .is_bne, .is_jump, .is_jirl, .mem_we, .mem_re, .gr_we,
        .dest, .rj_value, .rkd_value, .redirect, .redirect_pc, .retire_now, .to_wb,
        .wb_is_load, .wb_pc, .wb_dest, .wb_alu_result, .data_sram_en, .data_sram_we,
        .data_sram_addr, .data_sram_wdata
    );

    // the register write port doubles as the debug trace
    writeback_stage u_writeback (
        .clk, .reset, .to_wb, .wb_is_load, .wb_pc, .wb_dest, .wb_alu_result,
        .data_sram_rdata, .rf_we(debug_wb_rf_we), .rf_waddr(debug_wb_rf_wnum),
        .rf_wdata(debug_wb_rf_wdata), .wb_done, .debug_wb_pc
    );

endmodule

// ==== dv/cpu_properties.sv ====
`timescale 1ns/100ps

module cpu_properties (
    input logic        clk,
    input logic        reset,
    input logic        inst_sram_en,
    input logic [31:0] inst_sram_addr,
    input logic        data_sram_en,
    input logic        data_sram_we,
    input logic        debug_wb_rf_we
);

    int fail_count = 0;

    // a data write is always part of an enabled access
    we_has_en: assert property (@(posedge clk) disable iff (reset)
        data_sram_we |-> data_sram_en)
        else begin
            fail_count++;
            $error("data SRAM write strobe without enable");
        end

    // one register write per retired instruction
    single_wb: assert property (@(posedge clk) disable iff (reset)
        debug_wb_rf_we |=> !debug_wb_rf_we)
        else begin
            fail_count++;
            $error("register write strobe high on two consecutive cycles");
        end

    fetch_aligned: assert property (@(posedge clk) disable iff (reset)
        inst_sram_en |-> inst_sram_addr[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("instruction fetch from an unaligned address");
        end

endmodule

// ==== dv/cpu_tb.sv ====
`timescale 1ns/100ps

module cpu_tb;
    import cpu_pkg::*;

    localparam int cycles_per_word = 6;
    localparam int passes          = 4;

    logic        clk;
    logic        reset;
    logic        inst_sram_en;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_en;
    logic        data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic        debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] stim [256];
    logic [31:0] imem [64];
    logic [31:0] dmem [256];
    int          prog_len;
    int          trace_len;
    int          trace_idx = 0;
    int          errors = 0;

    cpu_top u_cpu_top (.*);

    bind cpu_top cpu_properties u_cpu_properties (
        .clk(clk), .reset(reset), .inst_sram_en(inst_sram_en),
        .inst_sram_addr(inst_sram_addr), .data_sram_en(data_sram_en),
        .data_sram_we(data_sram_we), .debug_wb_rf_we(debug_wb_rf_we)
    );

    function automatic logic [31:0] stim_word(input int idx);
        return stim[idx[7:0]];
    endfunction

    // program image starts at reset_pc
    function automatic logic [5:0] imem_index(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - reset_pc;
        return offset[7:2];
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // clock and SRAM models

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (inst_sram_en) begin
            inst_sram_rdata <= imem[imem_index(inst_sram_addr)];
        end
        if (data_sram_en && data_sram_we) begin
            dmem[data_sram_addr[9:2]] <= data_sram_wdata;
        end else if (data_sram_en) begin
            data_sram_rdata <= dmem[data_sram_addr[9:2]];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // trace checker

    task automatic check_writeback();
        int          base;
        logic [31:0] exp_pc;
        logic [31:0] num_word;
        logic [4:0]  exp_num;
        logic [31:0] exp_data;
        base = 2 + prog_len + 3 * trace_idx;
        assert (trace_idx < trace_len) else begin
            errors++;
            $display("** Error @%0t: writeback beyond the expected trace, pc %h r%0d",
                     $time, debug_wb_pc, debug_wb_rf_wnum);
        end
        if (trace_idx < trace_len) begin
            exp_pc   = stim_word(base);
            num_word = stim_word(base + 1);
            exp_num  = num_word[4:0];
            exp_data = stim_word(base + 2);
            assert (debug_wb_pc == exp_pc && debug_wb_rf_wnum == exp_num
                    && debug_wb_rf_wdata == exp_data) else begin
                errors++;
                $display("** Error @%0t: trace %0d got pc %h r%0d %h, expected pc %h r%0d %h",
                         $time, trace_idx, debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata,
                         exp_pc, exp_num, exp_data);
            end
            trace_idx++;
        end
    endtask

    // trace outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (!reset && debug_wb_rf_we) begin
            check_writeback();
        end
    end

    initial begin
        int limit;
        @(negedge reset);
        limit = prog_len * cycles_per_word * passes;
        repeat (limit) @(posedge clk);
        $display("timeout: only %0d of %0d trace entries after %0d cycles",
                 trace_idx, trace_len, limit);
        $display("Test failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        void'($urandom(32'h30940c8e));
        reset           <= 1'b1;
        inst_sram_rdata <= '0;
        data_sram_rdata <= '0;
        $readmemh("dv/cpu_stimulus.txt", stim);
        prog_len  = stim[0];
        trace_len = stim[1];
        for (int i = 0; i < 64; i++) begin
            imem[i[5:0]] = (i < prog_len) ? stim_word(2 + i) : 32'h0;
        end
        // data the program never stores to starts out random
        for (int i = 0; i < 256; i++) begin
            dmem[i[7:0]] <= $urandom;
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        wait (trace_idx == trace_len);
        repeat (10) @(posedge clk);
        $display("errors: %0d trace, %0d protocol; trace entries checked: %0d of %0d",
                 errors, u_cpu_top.u_cpu_properties.fail_count, trace_idx, trace_len);
        if (errors == 0 && u_cpu_top.u_cpu_properties.fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
design/cpu_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/regfile.sv
design/execute_stage.sv
design/writeback_stage.sv
design/cpu_top.sv
dv/cpu_properties.sv
dv/cpu_tb.sv

// ==== Makefile ====
# Verilator flow for the cpu testbench; every variable can be set on the command line

VERILATOR ?= verilator
TOP       ?= cpu_tb
SEED      ?= 1
LOG       ?= sim.log
FLIST     ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+seed+$(SEED) +verilator+error+limit+100

SOURCES := $(wildcard design/*.sv dv/*.sv) dv/cpu_stimulus.txt

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; \
	status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/cpu_stimulus.txt ====
// first line: program length, trace length; then one program word per line from reset_pc
// then one expected writeback per line: pc, register number, data
0000001e 00000015
14000024 // lu12i.w r4, 1
02bfec05 // addi.w  r5, r0, -5
029ffc06 // addi.w  r6, r0, 0x7ff
001018a7 // add.w   r7, r5, r6
001118a8 // sub.w   r8, r5, r6
001218a9 // slt     r9, r5, r6
001298aa // sltu    r10, r5, r6
001498ab // and     r11, r5, r6
001518ac // or      r12, r5, r6
001598ad // xor     r13, r5, r6
001418ae // nor     r14, r5, r6
0040d0cf // slli.w  r15, r6, 20
004490b0 // srli.w  r16, r5, 4
004884b1 // srai.w  r17, r5, 1
29802087 // st.w    r7, r4, 8
28802092 // ld.w    r18, r4, 8
02815400 // addi.w  r0, r0, 0x55
00101813 // add.w   r19, r0, r6
580008f2 // beq     r7, r18, +2 taken
50000000 // b 0, trap if reached
5c0008f2 // bne     r7, r18, +2 not taken
5c0008a6 // bne     r5, r6, +2 taken
50000000 // b 0, trap if reached
580008a6 // beq     r5, r6, +2 not taken
54000c00 // bl      +3
02800c15 // addi.w  r21, r0, 3
50000c00 // b       +3
02801c16 // addi.w  r22, r0, 7
4c000037 // jirl    r23, r1, 0
50000000 // b 0, end of program
1c000000 04 00001000
1c000004 05 fffffffb
1c000008 06 000007ff
1c00000c 07 000007fa
1c000010 08 fffff7fc
1c000014 09 00000001
1c000018 0a 00000000
1c00001c 0b 000007fb
1c000020 0c ffffffff
1c000024 0d fffff804
1c000028 0e 00000000
1c00002c 0f 7ff00000
1c000030 10 0fffffff
1c000034 11 fffffffd
1c00003c 12 000007fa
1c000040 00 00000055
1c000044 13 000007ff
1c000060 01 1c000064
1c00006c 16 00000007
1c000070 17 1c000074
1c000064 15 00000003
